//--- Makefile
TOP := cpu_tb

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator and run $(TOP)"
	@echo "  clean  remove the build directory"
	@echo "  help   show this list"

test:
	verilator --binary --timing --assert --top-module $(TOP) -Mdir obj_dir -f compile.f
	@out=$$(./obj_dir/V$(TOP)); \
	echo "$$out"; \
	echo "$$out" | grep -qx "Verification passed"

clean:
	rm -rf obj_dir

//--- bench/cpu_chk.sv
`timescale 1ns/1ps

module cpu_chk (
    input logic           clk,
    input logic           rstn,
    input rv_pkg::state_t state,
    input logic           mem_we,
    input logic           rf_we,
    input logic           instr_we
);
    import rv_pkg::*;

    // A store is a one-cycle strobe
    single_store: assert property (@(posedge clk) disable iff (!rstn) mem_we |=> !mem_we)
        else $error("mem_we stayed high for two cycles in a row");

    quiet_after_reset: assert property (@(posedge clk) !rstn |=> !mem_we && !rf_we)
        else $error("mem_we or rf_we high in the cycle after reset");

    legal_state: assert property (@(posedge clk) disable iff (!rstn)
        !$isunknown(state) && state inside {[S_FETCH:S_BRANCH]})
        else $error("sequencer state is not a defined value");

    fetch_only_load: assert property (@(posedge clk) disable iff (!rstn)
        instr_we |-> state == S_FETCH)
        else $error("instr_we high outside the fetch state");

endmodule

bind control_unit cpu_chk cpu_chk_inst (
    .clk      (clk),
    .rstn     (rstn),
    .state    (state),
    .mem_we   (mem_we),
    .rf_we    (rf_we),
    .instr_we (instr_we)
);

//--- bench/cpu_tb.sv
`timescale 1ns/1ps

module cpu_tb;
    import rv_pkg::*;

    localparam int K_R      = 0;
    localparam int K_I      = 1;
    localparam int K_MEM    = 2;
    localparam int K_BR     = 3;
    localparam int K_JAL    = 4;
    localparam int K_JALR   = 5;
    localparam int K_X0     = 6;
    localparam int MAX_ROWS = 40;

    logic              clk;
    logic              rstn;
    logic              prog_we;
    logic [MEM_AW-1:0] prog_addr;
    logic [XLEN-1:0]   prog_wdata;
    logic              st_valid;
    logic [XLEN-1:0]   st_addr;
    logic [XLEN-1:0]   st_data;

    int          row_kind [MAX_ROWS];
    int          row_op   [MAX_ROWS];
    int          row_rnd  [MAX_ROWS];
    int          row_a    [MAX_ROWS];
    int          row_b    [MAX_ROWS];
    int          n_rows;
    logic [31:0] prog [16];
    int          prog_len;
    logic [31:0] exp_addr [$];
    logic [31:0] exp_data [$];
    logic [31:0] got_addr [$];
    logic [31:0] got_data [$];
    int          n_checks;
    int          n_errors;
    int          cycle_cnt;
    int          cycle_limit;

    cpu_top cpu_top_inst (
        .clk        (clk),
        .rstn       (rstn),
        .prog_we    (prog_we),
        .prog_addr  (prog_addr),
        .prog_wdata (prog_wdata),
        .st_valid   (st_valid),
        .st_addr    (st_addr),
        .st_data    (st_data)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    // RV32I instruction formats
    function automatic logic [31:0] enc_r(int f7, int rs2, int rs1, int f3, int rd);
        return {f7[6:0], rs2[4:0], rs1[4:0], f3[2:0], rd[4:0], OP_R};
    endfunction

    function automatic logic [31:0] enc_i(int imm, int rs1, int f3, int rd, logic [6:0] op);
        return {imm[11:0], rs1[4:0], f3[2:0], rd[4:0], op};
    endfunction

    function automatic logic [31:0] enc_s(int imm, int rs2, int rs1);
        return {imm[11:5], rs2[4:0], rs1[4:0], 3'b010, imm[4:0], OP_STORE};
    endfunction

    function automatic logic [31:0] enc_b(int imm, int rs2, int rs1, int f3);
        return {imm[12], imm[10:5], rs2[4:0], rs1[4:0], f3[2:0], imm[4:1], imm[11], OP_BRANCH};
    endfunction

    function automatic logic [31:0] enc_j(int imm, int rd);
        return {imm[20], imm[10:1], imm[11], imm[19:12], rd[4:0], OP_JAL};
    endfunction

    function automatic logic [31:0] addi(int rd, int rs1, int imm);
        return enc_i(imm, rs1, 0, rd, OP_IMM);
    endfunction

    function automatic logic [31:0] sw(int rs2, int imm);
        return enc_s(imm, rs2, 0);
    endfunction

    // Reference results, op is {funct7[5], funct3}
    function automatic logic [31:0] expect_alu(logic [3:0] op, logic [31:0] a, logic [31:0] b);
        case (op)
            4'b0000: return a + b;
            4'b1000: return a - b;
            4'b0001: return a << b[4:0];
            4'b0010: return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
            4'b0011: return (a < b) ? 32'd1 : 32'd0;
            4'b0100: return a ^ b;
            4'b0101: return a >> b[4:0];
            4'b1101: return $signed(a) >>> b[4:0];
            4'b0110: return a | b;
            default: return a & b;
        endcase
    endfunction

    function automatic logic branch_taken(logic [2:0] f3, logic [31:0] a, logic [31:0] b);
        case (f3)
            3'b000:  return a == b;
            3'b001:  return a != b;
            3'b100:  return $signed(a) < $signed(b);
            3'b101:  return $signed(a) >= $signed(b);
            3'b110:  return a < b;
            default: return a >= b;
        endcase
    endfunction

    task automatic compare_value(string name, logic [31:0] got, logic [31:0] exp);
        n_checks++;
        if (got !== exp) begin
            n_errors++;
            $display("Fail at %0t ns: %s = 0x%h, expected 0x%h", $time, name, got, exp);
        end
    endtask

    task automatic add_row(int kind, int op, int rnd, int a, int b);
        row_kind[n_rows] = kind;
        row_op[n_rows]   = op;
        row_rnd[n_rows]  = rnd;
        row_a[n_rows]    = a;
        row_b[n_rows]    = b;
        n_rows++;
    endtask

    task automatic fill_table();
        int alu_codes [10];
        alu_codes = '{'h0, 'h8, 'h1, 'h2, 'h3, 'h4, 'h5, 'hd, 'h6, 'h7};
        n_rows = 0;
        foreach (alu_codes[i]) add_row(K_R, alu_codes[i], 1, 0, 0);
        foreach (alu_codes[i]) begin
            if (alu_codes[i] != 'h8) add_row(K_I, alu_codes[i], 1, 0, 0); // No SUBI
        end
        add_row(K_MEM, 0, 1, 0, 0);
        add_row(K_BR, 0, 0, 5, 5);
        add_row(K_BR, 0, 0, 5, 6);
        add_row(K_BR, 1, 0, 5, 6);
        add_row(K_BR, 1, 0, 5, 5);
        add_row(K_BR, 4, 0, -3, 2);
        add_row(K_BR, 4, 0, 2, -3);
        add_row(K_BR, 5, 0, 2, -3);
        add_row(K_BR, 5, 0, -3, 2);
        add_row(K_BR, 6, 0, 2, -3);
        add_row(K_BR, 6, 0, -3, 2);
        add_row(K_BR, 7, 0, -3, 2);
        add_row(K_BR, 7, 0, 2, -3);
        add_row(K_JAL, 0, 0, 11, 22);
        add_row(K_JALR, 0, 0, 11, 22);
        add_row(K_X0, 0, 1, 0, 0);
    endtask

    task automatic emit(logic [31:0] word);
        prog[prog_len] = word;
        prog_len++;
    endtask

    task automatic expect_store(int addr, logic [31:0] data);
        exp_addr.push_back(addr);
        exp_data.push_back(data);
    endtask

    task automatic build_program(int kind, int op, logic [11:0] a, logic [11:0] b);
        logic [31:0] a32;
        logic [31:0] b32;
        logic [31:0] imm;
        logic [3:0]  code;
        a32  = {{20{a[11]}}, a};
        b32  = {{20{b[11]}}, b};
        code = op[3:0];
        prog_len = 0;
        exp_addr.delete();
        exp_data.delete();
        case (kind)
            K_R: begin
                emit(addi(1, 0, a32));
                emit(addi(2, 0, b32));
                emit(enc_r(code[3] ? 'h20 : 0, 2, 1, 32'(code[2:0]), 3));
                emit(sw(3, 'h200));
                expect_store('h200, expect_alu(code, a32, b32));
            end
            K_I: begin
                imm = b32;
                if (code[1:0] == 2'b01) imm = (code[3] ? 32'h400 : 32'h0) | {27'b0, b[4:0]};
                emit(addi(1, 0, a32));
                emit(enc_i(imm, 1, 32'(code[2:0]), 3, OP_IMM));
                emit(sw(3, 'h200));
                expect_store('h200, expect_alu(code, a32, b32));
            end
            K_MEM: begin
                emit(addi(1, 0, a32));
                emit(sw(1, 'h204));
                emit(enc_i('h204, 0, 2, 4, OP_LOAD)); // lw x4
                emit(sw(4, 'h208));
                expect_store('h204, a32);
                expect_store('h208, a32);
            end
            K_BR: begin
                emit(addi(1, 0, a32));
                emit(addi(2, 0, b32));
                emit(addi(5, 0, 1));
                emit(enc_b(8, 2, 1, 32'(code[2:0])));
                emit(enc_j(8, 0)); // Fall through skips marker 2
                emit(addi(5, 0, 2));
                emit(sw(5, 'h200));
                expect_store('h200, branch_taken(code[2:0], a32, b32) ? 32'd2 : 32'd1);
            end
            K_JAL: begin
                emit(addi(7, 0, a32));
                emit(enc_j(8, 6)); // At byte 4
                emit(addi(7, 0, b32));
                emit(sw(6, 'h200));
                emit(sw(7, 'h204));
                expect_store('h200, 4 + 4);
                expect_store('h204, a32);
            end
            K_JALR: begin
                emit(addi(7, 0, a32));
                emit(addi(8, 0, 16));
                emit(enc_i(4, 8, 0, 6, OP_JALR)); // At byte 8, lands on byte 20
                emit(addi(7, 0, b32));
                emit(addi(7, 0, b32));
                emit(sw(6, 'h200));
                emit(sw(7, 'h204));
                expect_store('h200, 8 + 4);
                expect_store('h204, a32);
            end
            default: begin
                emit(addi(0, 0, a32));
                emit(sw(0, 'h200));
                emit(addi(9, 0, a32));
                emit(enc_r(0, 9, 9, 0, 0)); // add x0, x9, x9
                emit(sw(0, 'h204));
                expect_store('h200, 32'd0);
                expect_store('h204, 32'd0);
            end
        endcase
        emit(enc_j(0, 0));
    endtask

    task automatic run_program();
        got_addr.delete();
        got_data.delete();
        @(posedge clk);
        rstn <= 1'b0;
        for (int i = 0; i < 16; i++) begin
            prog_we    <= (i < prog_len); // Loaded while the core sits in reset
            prog_addr  <= MEM_AW'(i);
            prog_wdata <= prog[i];
            @(posedge clk);
        end
        rstn    <= 1'b1;
        prog_we <= 1'b0;
        while (got_addr.size() < exp_addr.size()) @(negedge clk);
        repeat (16) @(negedge clk); // Four turns of the final loop
        compare_value("store count", 32'(got_addr.size()), 32'(exp_addr.size()));
        for (int i = 0; i < exp_addr.size() && i < got_addr.size(); i++) begin
            compare_value("st_addr", got_addr[i], exp_addr[i]);
            compare_value("st_data", got_data[i], exp_data[i]);
        end
    endtask

    always @(negedge clk) begin
        if (rstn && st_valid) begin
            got_addr.push_back(st_addr);
            got_data.push_back(st_data);
        end
    end

    always @(posedge clk) begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_cnt > cycle_limit) begin
            $display("Timeout after %0d cycles, a program never finished its stores", cycle_cnt);
            $display("Verification failed");
            $finish;
        end
    end

    initial begin
        logic [11:0] a;
        logic [11:0] b;
        rstn        = 1'b0;
        prog_we     = 1'b0;
        prog_addr   = '0;
        prog_wdata  = '0;
        n_checks    = 0;
        n_errors    = 0;
        cycle_cnt   = 0;
        void'($urandom(32'he84b_769e));
        fill_table();
        cycle_limit = n_rows * 200;
        for (int r = 0; r < n_rows; r++) begin
            a = row_rnd[r] != 0 ? 12'($urandom) : 12'(row_a[r]);
            b = row_rnd[r] != 0 ? 12'($urandom) : 12'(row_b[r]);
            build_program(row_kind[r], row_op[r], a, b);
            run_program();
        end
        $display("Checks: %0d, errors: %0d", n_checks, n_errors);
        if (n_errors == 0) begin
            $display("Verification passed");
        end else begin
            $display("Verification failed");
        end
        $finish;
    end

endmodule

//--- compile.f
src/rv_pkg.sv
src/alu.sv
src/alu_op_decode.sv
src/reg_file.sv
src/unified_mem.sv
src/control_unit.sv
src/datapath.sv
src/cpu_top.sv
bench/cpu_chk.sv
bench/cpu_tb.sv

//--- src/alu.sv
`timescale 1ns/1ps

module alu (
    input  logic [rv_pkg::XLEN-1:0] a,
    input  logic [rv_pkg::XLEN-1:0] b,
    input  rv_pkg::alu_op_t         op,
    output logic [rv_pkg::XLEN-1:0] result,
    output logic                    zero
);
    import rv_pkg::*;

    logic [4:0] shamt;

    assign shamt = b[4:0];

    always_comb begin
        case (op)
            ALU_ADD:  result = a + b;
            ALU_SUB:  result = a - b;
            ALU_SLL:  result = a << shamt;
            ALU_SLT:  result = {{(XLEN-1){1'b0}}, $signed(a) < $signed(b)};
            ALU_SLTU: result = {{(XLEN-1){1'b0}}, a < b};
            ALU_XOR:  result = a ^ b;
            ALU_SRL:  result = a >> shamt;
            ALU_SRA:  result = $signed(a) >>> shamt;
            ALU_OR:   result = a | b;
            ALU_AND:  result = a & b;
            default:  result = '0;
        endcase
    end

    assign zero = (result == '0);

endmodule

//--- src/alu_op_decode.sv
`timescale 1ns/1ps

module alu_op_decode (
    input  logic [6:0]      opcode,
    input  logic [2:0]      funct3,
    input  logic [6:0]      funct7,
    input  logic            alu_ctrl,
    output rv_pkg::alu_op_t alu_op
);
    import rv_pkg::*;

    always_comb begin
        alu_op = ALU_ADD;
        if (!alu_ctrl) begin
            case (opcode)
                OP_R, OP_IMM: begin
                    case (funct3)
                        3'b000: begin
                            // Only the register form has SUB
                            if (opcode == OP_R && funct7[5]) begin
                                alu_op = ALU_SUB;
                            end else begin
                                alu_op = ALU_ADD;
                            end
                        end
                        3'b001: alu_op = ALU_SLL;
                        3'b010: alu_op = ALU_SLT;
                        3'b011: alu_op = ALU_SLTU;
                        3'b100: alu_op = ALU_XOR;
                        3'b101: alu_op = funct7[5] ? ALU_SRA : ALU_SRL;
                        3'b110: alu_op = ALU_OR;
                        default: alu_op = ALU_AND;
                    endcase
                end
                OP_BRANCH: begin
                    case (funct3[2:1])
                        2'b10:   alu_op = ALU_SLT;  // BLT, BGE
                        2'b11:   alu_op = ALU_SLTU; // BLTU, BGEU
                        default: alu_op = ALU_SUB;  // BEQ, BNE
                    endcase
                end
                default: alu_op = ALU_ADD;
            endcase
        end
    end

endmodule

//--- src/control_unit.sv
`timescale 1ns/1ps

module control_unit (
    input  logic                     clk,
    input  logic                     rstn,
    input  logic [rv_pkg::XLEN-1:0]  instr,
    input  logic                     alu_zero,
    output rv_pkg::fmt_t             imm_src,
    output logic                     pc_we,
    output logic                     mem_addr_src,
    output logic                     mem_we,
    output logic                     instr_we,
    output logic                     rf_we,
    output logic [1:0]               result_src,
    output rv_pkg::alu_op_t          alu_op,
    output logic [1:0]               alu_a_src,
    output logic [1:0]               alu_b_src
);
    import rv_pkg::*;

    logic [6:0] opcode;
    logic [2:0] funct3;
    logic [6:0] funct7;
    state_t     state;
    state_t     next_state;
    logic       branch;
    logic       pc_update;
    logic       alu_ctrl;
    logic       is_jump;

    assign opcode  = instr[6:0];
    assign funct3  = instr[14:12];
    assign funct7  = instr[31:25];
    assign is_jump = (opcode == OP_JAL) || (opcode == OP_JALR);

    always_comb begin
        case (opcode)
            OP_R:                             imm_src = FMT_R;
            OP_IMM, OP_LOAD, OP_JALR:         imm_src = FMT_I;
            OP_FENCE, OP_SYSTEM:              imm_src = FMT_I;
            OP_STORE:                         imm_src = FMT_S;
            OP_BRANCH:                        imm_src = FMT_B;
            OP_LUI, OP_AUIPC:                 imm_src = FMT_U;
            OP_JAL:                           imm_src = FMT_J;
            default:                          imm_src = FMT_UNKNOWN;
        endcase
    end

    always_ff @(posedge clk) begin
        if (!rstn) begin
            state <= S_FETCH;
        end else begin
            state <= next_state;
        end
    end

    always_comb begin
        next_state = S_FETCH;
        case (state)
            S_FETCH: next_state = S_DECODE;
            S_DECODE: begin
                case (opcode)
                    OP_LOAD, OP_STORE: next_state = S_MEM_ADDR;
                    OP_R:              next_state = S_EXEC_R;
                    OP_IMM:            next_state = S_EXEC_I;
                    OP_JAL:            next_state = S_JAL;
                    OP_JALR:           next_state = S_JALR;
                    OP_BRANCH:         next_state = S_BRANCH;
                    default:           next_state = S_FETCH; // Unsupported acts as a no-op
                endcase
            end
            S_MEM_ADDR: next_state = (opcode == OP_STORE) ? S_MEM_WRITE : S_MEM_READ;
            S_MEM_READ: next_state = S_MEM_WB;
            S_EXEC_R, S_EXEC_I, S_JAL, S_JALR: next_state = S_ALU_WB;
            default:    next_state = S_FETCH;
        endcase
    end

    // Branch taken when zero flag, flipped by funct3 bits, says so
    assign pc_we = ((alu_zero ^ funct3[0] ^ funct3[2]) & branch) | pc_update;

    always_comb begin
        mem_addr_src = 1'b0;
        alu_a_src    = A_SRC_PC;
        alu_b_src    = B_SRC_REG;
        alu_ctrl     = 1'b0;
        result_src   = RES_ALU_OUT;
        mem_we       = 1'b0;
        rf_we        = 1'b0;
        instr_we     = 1'b0;
        pc_update    = 1'b0;
        branch       = 1'b0;
        case (state)
            S_FETCH: begin
                alu_b_src  = B_SRC_FOUR; // PC + 4
                alu_ctrl   = 1'b1;
                result_src = RES_ALU;
                instr_we   = 1'b1;
                pc_update  = 1'b1;
            end
            S_DECODE: begin
                alu_a_src = A_SRC_OLD_PC; // Jump and branch target
                alu_b_src = B_SRC_IMM;
                alu_ctrl  = 1'b1;
            end
            S_MEM_ADDR: begin
                alu_a_src = A_SRC_REG;
                alu_b_src = B_SRC_IMM;
                alu_ctrl  = 1'b1;
            end
            S_MEM_READ: mem_addr_src = 1'b1;
            S_MEM_WB: begin
                result_src = RES_DATA;
                rf_we      = 1'b1;
            end
            S_MEM_WRITE: begin
                mem_addr_src = 1'b1;
                mem_we       = 1'b1;
            end
            S_EXEC_R: alu_a_src = A_SRC_REG;
            S_ALU_WB: begin
                rf_we = 1'b1;
                if (is_jump) begin
                    // Link value is old PC + 4
                    alu_a_src  = A_SRC_OLD_PC;
                    alu_b_src  = B_SRC_FOUR;
                    alu_ctrl   = 1'b1;
                    result_src = RES_ALU;
                end
            end
            S_EXEC_I: begin
                alu_a_src = A_SRC_REG;
                alu_b_src = B_SRC_IMM;
            end
            S_JAL: pc_update = 1'b1; // Target from decode
            S_JALR: begin
                alu_a_src  = A_SRC_REG;
                alu_b_src  = B_SRC_IMM;
                alu_ctrl   = 1'b1;
                result_src = RES_ALU;
                pc_update  = 1'b1;
            end
            S_BRANCH: begin
                alu_a_src = A_SRC_REG;
                branch    = 1'b1;
            end
            default: ;
        endcase
    end

    alu_op_decode alu_op_decode_inst (
        .opcode   (opcode),
        .funct3   (funct3),
        .funct7   (funct7),
        .alu_ctrl (alu_ctrl),
        .alu_op   (alu_op)
    );

endmodule

//--- src/cpu_top.sv
`timescale 1ns/1ps

module cpu_top (
    input  logic                      clk,
    input  logic                      rstn,
    input  logic                      prog_we,
    input  logic [rv_pkg::MEM_AW-1:0] prog_addr,
    input  logic [rv_pkg::XLEN-1:0]   prog_wdata,
    output logic                      st_valid,
    output logic [rv_pkg::XLEN-1:0]   st_addr,
    output logic [rv_pkg::XLEN-1:0]   st_data
);
    import rv_pkg::*;

    logic            instr_we;
    logic            pc_we;
    logic            rf_we;
    logic            mem_we;
    logic            mem_addr_src;
    logic [1:0]      result_src;
    logic [1:0]      alu_a_src;
    logic [1:0]      alu_b_src;
    fmt_t            imm_src;
    alu_op_t         alu_op;
    logic            alu_zero;
    logic [XLEN-1:0] instr;
    logic [XLEN-1:0] mem_addr;
    logic [XLEN-1:0] mem_wdata;
    logic [XLEN-1:0] mem_rdata;

    control_unit control_unit_inst (
        .clk          (clk),
        .rstn         (rstn),
        .instr        (instr),
        .alu_zero     (alu_zero),
        .imm_src      (imm_src),
        .pc_we        (pc_we),
        .mem_addr_src (mem_addr_src),
        .mem_we       (mem_we),
        .instr_we     (instr_we),
        .rf_we        (rf_we),
        .result_src   (result_src),
        .alu_op       (alu_op),
        .alu_a_src    (alu_a_src),
        .alu_b_src    (alu_b_src)
    );

    datapath datapath_inst (
        .clk          (clk),
        .rstn         (rstn),
        .instr_we     (instr_we),
        .pc_we        (pc_we),
        .rf_we        (rf_we),
        .mem_addr_src (mem_addr_src),
        .result_src   (result_src),
        .alu_a_src    (alu_a_src),
        .alu_b_src    (alu_b_src),
        .imm_src      (imm_src),
        .alu_op       (alu_op),
        .mem_rdata    (mem_rdata),
        .instr        (instr),
        .mem_addr     (mem_addr),
        .mem_wdata    (mem_wdata),
        .alu_zero     (alu_zero)
    );

    unified_mem unified_mem_inst (
        .clk        (clk),
        .we         (mem_we),
        .addr       (mem_addr[MEM_AW+1:2]), // Byte to word address
        .wdata      (mem_wdata),
        .prog_we    (prog_we),
        .prog_addr  (prog_addr),
        .prog_wdata (prog_wdata),
        .rdata      (mem_rdata)
    );

    assign st_valid = mem_we;
    assign st_addr  = mem_addr;
    assign st_data  = mem_wdata;

endmodule

//--- src/datapath.sv
`timescale 1ns/1ps

module datapath (
    input  logic                    clk,
    input  logic                    rstn,
    input  logic                    instr_we,
    input  logic                    pc_we,
    input  logic                    rf_we,
    input  logic                    mem_addr_src,
    input  logic [1:0]              result_src,
    input  logic [1:0]              alu_a_src,
    input  logic [1:0]              alu_b_src,
    input  rv_pkg::fmt_t            imm_src,
    input  rv_pkg::alu_op_t         alu_op,
    input  logic [rv_pkg::XLEN-1:0] mem_rdata,
    output logic [rv_pkg::XLEN-1:0] instr,
    output logic [rv_pkg::XLEN-1:0] mem_addr,
    output logic [rv_pkg::XLEN-1:0] mem_wdata,
    output logic                    alu_zero
);
    import rv_pkg::*;

    logic [XLEN-1:0] pc;
    logic [XLEN-1:0] old_pc;
    logic [XLEN-1:0] mem_data;
    logic [XLEN-1:0] reg_a;
    logic [XLEN-1:0] reg_b;
    logic [XLEN-1:0] alu_out;
    logic [XLEN-1:0] rd1;
    logic [XLEN-1:0] rd2;
    logic [XLEN-1:0] imm_ext;
    logic [XLEN-1:0] src_a;
    logic [XLEN-1:0] src_b;
    logic [XLEN-1:0] alu_result;
    logic [XLEN-1:0] result;

    always_ff @(posedge clk) begin
        if (!rstn) begin
            pc <= '0;
        end else if (pc_we) begin
            pc <= result;
        end
    end

    always_ff @(posedge clk) begin
        if (instr_we) begin
            instr  <= mem_rdata;
            old_pc <= pc; // PC of the instruction being run
        end
        mem_data <= mem_rdata;
        reg_a    <= rd1;
        reg_b    <= rd2;
        alu_out  <= alu_result;
    end

    always_comb begin
        case (imm_src)
            FMT_I:   imm_ext = {{20{instr[31]}}, instr[31:20]};
            FMT_S:   imm_ext = {{20{instr[31]}}, instr[31:25], instr[11:7]};
            FMT_B:   imm_ext = {{19{instr[31]}}, instr[31], instr[7], instr[30:25],
                                instr[11:8], 1'b0};
            FMT_U:   imm_ext = {instr[31:12], 12'b0};
            FMT_J:   imm_ext = {{11{instr[31]}}, instr[31], instr[19:12], instr[20],
                                instr[30:21], 1'b0};
            default: imm_ext = '0;
        endcase
    end

    always_comb begin
        case (alu_a_src)
            A_SRC_OLD_PC: src_a = old_pc;
            A_SRC_REG:    src_a = reg_a;
            default:      src_a = pc;
        endcase
        case (alu_b_src)
            B_SRC_IMM:  src_b = imm_ext;
            B_SRC_FOUR: src_b = 32'd4;
            default:    src_b = reg_b;
        endcase
        case (result_src)
            RES_DATA: result = mem_data;
            RES_ALU:  result = alu_result;
            default:  result = alu_out;
        endcase
    end

    assign mem_addr  = mem_addr_src ? alu_out : pc;
    assign mem_wdata = reg_b;

    reg_file reg_file_inst (
        .clk (clk),
        .we  (rf_we),
        .ra1 (instr[19:15]),
        .ra2 (instr[24:20]),
        .wa  (instr[11:7]),
        .wd  (result),
        .rd1 (rd1),
        .rd2 (rd2)
    );

    alu alu_inst (
        .a      (src_a),
        .b      (src_b),
        .op     (alu_op),
        .result (alu_result),
        .zero   (alu_zero)
    );

endmodule

//--- src/reg_file.sv
`timescale 1ns/1ps

module reg_file (
    input  logic                    clk,
    input  logic                    we,
    input  logic [4:0]              ra1,
    input  logic [4:0]              ra2,
    input  logic [4:0]              wa,
    input  logic [rv_pkg::XLEN-1:0] wd,
    output logic [rv_pkg::XLEN-1:0] rd1,
    output logic [rv_pkg::XLEN-1:0] rd2
);
    import rv_pkg::*;

    logic [XLEN-1:0] regs [32];

    always_ff @(posedge clk) begin
        if (we && wa != 5'd0) begin
            regs[wa] <= wd;
        end
    end

    // x0 is never written so force it here
    assign rd1 = (ra1 == 5'd0) ? '0 : regs[ra1];
    assign rd2 = (ra2 == 5'd0) ? '0 : regs[ra2];

endmodule

//--- src/rv_pkg.sv
package rv_pkg;

    localparam int XLEN      = 32;
    localparam int MEM_WORDS = 256;
    localparam int MEM_AW    = 8;

    typedef enum logic [3:0] {
        S_FETCH,
        S_DECODE,
        S_MEM_ADDR,
        S_MEM_READ,
        S_MEM_WB,
        S_MEM_WRITE,
        S_EXEC_R,
        S_ALU_WB,
        S_EXEC_I,
        S_JAL,
        S_JALR,
        S_BRANCH
    } state_t;

    typedef enum logic [6:0] {
        OP_R      = 7'b0110011,
        OP_IMM    = 7'b0010011,
        OP_LOAD   = 7'b0000011,
        OP_STORE  = 7'b0100011,
        OP_BRANCH = 7'b1100011,
        OP_JAL    = 7'b1101111,
        OP_JALR   = 7'b1100111,
        OP_LUI    = 7'b0110111,
        OP_AUIPC  = 7'b0010111,
        OP_FENCE  = 7'b0001111,
        OP_SYSTEM = 7'b1110011
    } opcode_t;

    typedef enum logic [2:0] {
        FMT_UNKNOWN,
        FMT_R,
        FMT_I,
        FMT_S,
        FMT_B,
        FMT_U,
        FMT_J
    } fmt_t;

    typedef enum logic [3:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_SLL,
        ALU_SLT,
        ALU_SLTU,
        ALU_XOR,
        ALU_SRL,
        ALU_SRA,
        ALU_OR,
        ALU_AND
    } alu_op_t;

    // ALU operand A sources
    localparam logic [1:0] A_SRC_PC     = 2'b00;
    localparam logic [1:0] A_SRC_OLD_PC = 2'b01;
    localparam logic [1:0] A_SRC_REG    = 2'b10;

    // ALU operand B sources
    localparam logic [1:0] B_SRC_REG  = 2'b00;
    localparam logic [1:0] B_SRC_IMM  = 2'b01;
    localparam logic [1:0] B_SRC_FOUR = 2'b10;

    // Result bus sources
    localparam logic [1:0] RES_ALU_OUT = 2'b00;
    localparam logic [1:0] RES_DATA    = 2'b01;
    localparam logic [1:0] RES_ALU     = 2'b10;

endpackage

//--- src/unified_mem.sv
`timescale 1ns/1ps

module unified_mem (
    input  logic                      clk,
    input  logic                      we,
    input  logic [rv_pkg::MEM_AW-1:0] addr,
    input  logic [rv_pkg::XLEN-1:0]   wdata,
    input  logic                      prog_we,
    input  logic [rv_pkg::MEM_AW-1:0] prog_addr,
    input  logic [rv_pkg::XLEN-1:0]   prog_wdata,
    output logic [rv_pkg::XLEN-1:0]   rdata
);
    import rv_pkg::*;

    logic [XLEN-1:0] mem [MEM_WORDS];

    always_ff @(posedge clk) begin
        if (prog_we) begin
            mem[prog_addr] <= prog_wdata; // Program load
        end else if (we) begin
            mem[addr] <= wdata;
        end
    end

    assign rdata = mem[addr];

endmodule
